// File: all.f
corr_pkg.sv
corr_sequencer.sv
chan_state_ram.sv
corr_tap_chain.sv
corr_result_stage.sv
bit_corr_top.sv
tb_clock_gen.sv
bit_corr_tb.sv

// File: bit_corr_tb.sv
module bit_corr_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import corr_pkg::*;

  localparam int unsigned corr_sel = 2;
  localparam logic [corr_len-1:0] weights = corr_table[corr_sel];
  localparam int sample_max = (1 << (sample_width - 1)) - 1;
  localparam int sample_min = -(1 << (sample_width - 1));
  localparam int wait_limit = 400;

  typedef struct packed {
    corr_result_t result;
    logic [31:0]  cycle;
  } expect_t;

  logic         clk;
  logic         reset;
  logic         in_valid;
  logic         in_ready;
  corr_frame_t  in_frame;
  logic         out_valid;
  logic         out_ready;
  corr_result_t out_result;

  // history per channel, newest sample at index 0
  int           hist [num_lanes][corr_len];
  expect_t      exp_q [$];
  int           cycle;
  int           mismatches;
  int           protocol_errors;
  int           timeouts;
  int           stall_cycles;
  logic         backpressure;
  logic         ready_low;
  logic         check_latency;
  logic         holding;
  corr_result_t held_result;

  tb_clock_gen #(.period(20)) i_tb_clock_gen (.clk(clk));

  bit_corr_top #(
    .corr_sel (corr_sel)
  ) i_bit_corr_top (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_frame   (in_frame),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result)
  );

  //////////////////////////////
  // reference model

  task automatic clear_model();
    for (int k = 0; k < num_lanes; k++) begin
      for (int j = 0; j < corr_len; j++) begin
        hist[k][j] = 0;
      end
    end
    exp_q.delete();
  endtask

  task automatic accept_frame(input corr_frame_t frame);
    expect_t exp;
    int      s;
    int      acc;
    for (int k = 0; k < num_lanes; k++) begin
      for (int j = corr_len - 1; j > 0; j--) begin
        hist[k][j] = hist[k][j-1];
      end
      // low bits as a two's complement sample, upper bits ignored
      s = int'(frame.lanes[k][sample_width-1:0]);
      if (s > sample_max) begin
        s = s - (1 << sample_width);
      end
      hist[k][0] = s;
      acc = 0;
      for (int j = 0; j < corr_len; j++) begin
        acc = weights[j] ? acc + hist[k][j] : acc - hist[k][j];
      end
      exp.result.lanes[k] = lane_out_t'(acc);
    end
    exp.cycle = cycle;
    exp_q.push_back(exp);
  endtask

  task automatic check_output();
    expect_t exp;
    assert (exp_q.size() != 0)
    else begin
      $display("output transfer at %0t with no frame outstanding", $time);
      protocol_errors++;
    end
    if (exp_q.size() != 0) begin
      exp = exp_q.pop_front();
      for (int k = 0; k < num_lanes; k++) begin
        assert (out_result.lanes[k] == exp.result.lanes[k])
        else begin
          $display("Error at %0t: out_result lane %0d got %0d expected %0d",
                   $time, k, out_result.lanes[k], exp.result.lanes[k]);
          mismatches++;
        end
      end
      if (check_latency) begin
        assert (cycle - int'(exp.cycle) == 11)
        else begin
          $display("latency of %0d cycles at %0t instead of 11", cycle - int'(exp.cycle), $time);
          protocol_errors++;
        end
      end
    end
  endtask

  //////////////////////////////
  // bus monitor

  always @(posedge clk) begin
    cycle++;
    if (reset) begin
      clear_model();
      holding = 1'b0;
    end else begin
      if (in_valid && in_ready) begin
        accept_frame(in_frame);
      end
      if (holding) begin
        assert (out_valid)
        else begin
          $display("out_valid dropped at %0t before out_ready was seen", $time);
          protocol_errors++;
        end
        assert (out_result == held_result)
        else begin
          $display("Error at %0t: out_result while waiting got %h expected %h",
                   $time, out_result, held_result);
          mismatches++;
        end
      end
      if (i_bit_corr_top.stall) begin
        stall_cycles++;
        assert (!in_ready)
        else begin
          $display("in_ready high at %0t while the result stage stalls", $time);
          protocol_errors++;
        end
      end
      if (out_valid && out_ready) begin
        check_output();
      end
      holding = out_valid && !out_ready;
      held_result = out_result;
    end
  end

  //////////////////////////////
  // stimulus

  task automatic tick();
    @(posedge clk);
    if (ready_low) begin
      out_ready <= 1'b0;
    end else if (backpressure) begin
      out_ready <= ($urandom % 8) == 0;
    end else begin
      out_ready <= 1'b1;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) tick();
  endtask

  task automatic apply_reset();
    reset <= 1'b1;
    in_valid <= 1'b0;
    repeat (5) tick();
    reset <= 1'b0;
    tick();
    assert (!out_valid)
    else begin
      $display("out_valid high at %0t right after reset", $time);
      protocol_errors++;
    end
  endtask

  // hold one frame on the bus until it is taken
  task automatic send_frame(input corr_frame_t frame);
    int waited;
    if (timeouts != 0) return;
    in_valid <= 1'b1;
    in_frame <= frame;
    waited = 0;
    do begin
      tick();
      waited++;
    end while (!in_ready && waited < wait_limit);
    if (!in_ready) begin
      $display("timeout: frame not accepted within %0d cycles", wait_limit);
      timeouts++;
    end
    in_valid <= 1'b0;
  endtask

  task automatic drain();
    int waited;
    if (timeouts != 0) return;
    waited = 0;
    while ((exp_q.size() != 0 || out_valid) && waited < wait_limit) begin
      tick();
      waited++;
    end
    if (exp_q.size() != 0 || out_valid) begin
      $display("timeout: %0d results still missing after %0d cycles", exp_q.size(), wait_limit);
      timeouts++;
    end
  endtask

  function automatic lane_in_t make_lane(input int value);
    lane_in_t lane;
    lane = lane_in_t'($urandom);
    lane[sample_width-1:0] = value[sample_width-1:0];
    return lane;
  endfunction

  function automatic corr_frame_t random_frame();
    corr_frame_t frame;
    for (int k = 0; k < num_lanes; k++) begin
      frame.lanes[k] = lane_in_t'($urandom);
    end
    return frame;
  endfunction

  task automatic send_impulse();
    corr_frame_t frame;
    int          lane;
    int          value;
    lane = int'($urandom % num_lanes);
    value = int'($urandom % 31) + 1;
    if ($urandom % 2 == 1) begin
      value = -value;
    end
    for (int i = 0; i < corr_len + 2; i++) begin
      for (int k = 0; k < num_lanes; k++) begin
        frame.lanes[k] = make_lane((i == 0 && k == lane) ? value : 0);
      end
      send_frame(frame);
    end
  endtask

  task automatic send_extremes();
    corr_frame_t frame;
    int          value;
    for (int i = 0; i < 3 * corr_len; i++) begin
      for (int k = 0; k < num_lanes; k++) begin
        // first block lines up with the weights, even lanes high, odd lanes low
        if (i < corr_len) begin
          value = (weights[corr_len-1-i] ^ k[0]) ? sample_max : sample_min;
        end else if (i < 2 * corr_len) begin
          value = sample_min;
        end else begin
          value = sample_max;
        end
        frame.lanes[k] = make_lane(value);
      end
      send_frame(frame);
    end
  endtask

  task automatic finish_run();
    $display("checks done: %0d mismatches, %0d protocol errors, %0d timeouts",
             mismatches, protocol_errors, timeouts);
    if (mismatches + protocol_errors + timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  initial begin
    reset = 1'b1;
    in_valid = 1'b0;
    in_frame = '0;
    out_ready = 1'b0;
    backpressure = 1'b0;
    ready_low = 1'b0;
    check_latency = 1'b1;
    void'($urandom(83518));
    apply_reset();
    send_impulse();
    drain();
    // back to back with out_ready high
    repeat (30) send_frame(random_frame());
    drain();
    repeat (40) begin
      idle(int'($urandom % 4));
      send_frame(random_frame());
    end
    drain();
    check_latency = 1'b0;
    backpressure = 1'b1;
    repeat (40) begin
      idle(int'($urandom % 3));
      send_frame(random_frame());
    end
    backpressure = 1'b0;
    drain();
    check_latency = 1'b1;
    assert (stall_cycles > 0)
    else begin
      $display("back-pressure never stalled the pipeline");
      protocol_errors++;
    end
    send_extremes();
    drain();
    // second reset with a result held at the output and a frame in flight
    ready_low = 1'b1;
    repeat (2) send_frame(random_frame());
    idle(4);
    apply_reset();
    ready_low = 1'b0;
    repeat (20) send_frame(random_frame());
    drain();
    assert (exp_q.size() == 0)
    else begin
      $display("%0d results were never delivered", exp_q.size());
      protocol_errors++;
    end
    finish_run();
  end

endmodule

// File: bit_corr_top.sv
module bit_corr_top #(
  parameter int unsigned corr_sel = 0
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  corr_pkg::corr_frame_t  in_frame,
  output logic                   out_valid,
  input  logic                   out_ready,
  output corr_pkg::corr_result_t out_result
);
  import corr_pkg::*;

  tap_step_t    step;
  corr_result_t bank;
  logic         frame_done;
  logic         stall;

  corr_sequencer i_corr_sequencer (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_frame (in_frame),
    .stall    (stall),
    .step     (step)
  );

  corr_tap_chain #(
    .corr_sel (corr_sel)
  ) i_corr_tap_chain (
    .clk        (clk),
    .reset      (reset),
    .step       (step),
    .stall      (stall),
    .bank       (bank),
    .frame_done (frame_done)
  );

  corr_result_stage i_corr_result_stage (
    .clk        (clk),
    .reset      (reset),
    .bank       (bank),
    .frame_done (frame_done),
    .stall      (stall),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result)
  );

endmodule

// File: chan_state_ram.sv
module chan_state_ram (
  input  logic                clk,
  input  logic                reset,
  input  logic                we,
  input  corr_pkg::lane_idx_t wr_addr,
  input  corr_pkg::lane_idx_t rd_addr,
  input  corr_pkg::acc_t      wr_data,
  output corr_pkg::acc_t      rd_data
);
  import corr_pkg::*;

  // one partial sum per channel
  acc_t mem [num_lanes];

  // read-first, registered read
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < num_lanes; i++) begin
        mem[i] <= '0;
      end
      rd_data <= '0;
    end else begin
      rd_data <= mem[rd_addr];
      if (we) begin
        mem[wr_addr] <= wr_data;
      end
    end
  end

endmodule

// File: corr_pkg.sv
package corr_pkg;

  //////////////////////////////
  // widths

  // channel count, must stay a power of two
  localparam int num_lanes = 8;

  // input lane container, low sample_width bits carry the sample
  localparam int lane_in_width = 8;
  localparam int sample_width = 6;

  // 16 taps of +-32 fit well inside 12 bits
  localparam int acc_width = 12;
  localparam int lane_out_width = 16;

  localparam int lane_idx_width = $clog2(num_lanes);

  // number of taps in the correlator
  localparam int corr_len = 16;

  //////////////////////////////
  // scalar types

  typedef logic [lane_idx_width-1:0] lane_idx_t;
  typedef logic signed [sample_width-1:0] sample_t;
  typedef logic signed [acc_width-1:0] acc_t;
  typedef logic [lane_in_width-1:0] lane_in_t;
  typedef logic signed [lane_out_width-1:0] lane_out_t;

  //////////////////////////////
  // stream payloads

  typedef struct packed {
    lane_in_t [num_lanes-1:0] lanes;
  } corr_frame_t;

  // one sign-extended sum per channel
  typedef struct packed {
    lane_out_t [num_lanes-1:0] lanes;
  } corr_result_t;

  // per-cycle command from the sequencer into the taps
  typedef struct packed {
    logic      step;
    sample_t   sample;
    lane_idx_t rd_addr;
    lane_idx_t wr_addr;
    logic      last;
  } tap_step_t;

  //////////////////////////////
  // weight sequences

  // 1 is +1, 0 is -1; bit j weights the sample j frames back
  localparam logic [corr_len-1:0] corr_table [4] = '{
    16'b1111_1001_1010_1000,
    16'b0001_0011_0101_1111,
    16'b1110_1101_0011_0000,
    16'b1010_0110_1100_1011
  };

endpackage

// File: corr_result_stage.sv
module corr_result_stage (
  input  logic                   clk,
  input  logic                   reset,
  input  corr_pkg::corr_result_t bank,
  input  logic                   frame_done,
  output logic                   stall,
  output logic                   out_valid,
  input  logic                   out_ready,
  output corr_pkg::corr_result_t out_result
);
  import corr_pkg::*;

  logic pending;
  logic load;

  // bank is complete the cycle after frame_done
  assign load = pending & (~out_valid | out_ready);

  // finished bank cannot move, so upstream must not overwrite it
  assign stall = pending & out_valid & ~out_ready;

  //////////////////////////////
  // pending flag

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (frame_done) begin
      pending <= 1'b1;
    end else if (load) begin
      pending <= 1'b0;
    end
  end

  //////////////////////////////
  // output register

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      out_result <= '0;
    end else if (load) begin
      out_valid <= 1'b1;
      out_result <= bank;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  a_out_stable : assert property (@(posedge clk) disable iff (reset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_result)));

  // the sequencer stall must keep a second frame from finishing
  a_no_overrun : assert property (@(posedge clk) disable iff (reset)
    frame_done |-> !pending);

endmodule

// File: corr_sequencer.sv
module corr_sequencer (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  corr_pkg::corr_frame_t in_frame,
  input  logic                  stall,
  output corr_pkg::tap_step_t   step
);
  import corr_pkg::*;

  localparam lane_idx_t last_lane = lane_idx_t'(num_lanes - 1);

  corr_frame_t frame_q;
  tap_step_t   step_q;
  lane_idx_t   count;

  logic        accept;
  logic        issue;
  lane_idx_t   next_lane;
  corr_frame_t frame_src;

  //////////////////////////////
  // input handshake

  // step_q.step doubles as the busy flag for the current frame
  assign in_ready = ~step_q.step & ~stall;
  assign accept = in_valid & in_ready;

  // channel 0 comes straight off the bus, the rest from the held frame
  assign issue = accept | (step_q.step & (count != last_lane));
  assign next_lane = accept ? lane_idx_t'(0) : count + lane_idx_t'(1);
  assign frame_src = accept ? in_frame : frame_q;

  always_ff @(posedge clk) begin
    if (accept) begin
      frame_q <= in_frame;
    end
  end

  //////////////////////////////
  // channel counter and addresses

  always_ff @(posedge clk) begin
    if (reset) begin
      step_q <= '0;
      count <= '0;
    end else if (!stall) begin
      step_q.step <= issue;
      step_q.sample <= sample_t'(frame_src.lanes[next_lane][sample_width-1:0]);
      // read one channel ahead, write the one processed last cycle
      step_q.rd_addr <= issue ? next_lane + lane_idx_t'(1) : lane_idx_t'(0);
      step_q.wr_addr <= issue ? next_lane - lane_idx_t'(1) : last_lane;
      // the cycle after the final step writes the last channel
      step_q.last <= step_q.step & (count == last_lane);
      count <= issue ? next_lane : lane_idx_t'(0);
    end
  end

  // frozen step while stalled
  always_comb begin
    step = step_q;
    step.step = step_q.step & ~stall;
    step.last = step_q.last & ~stall;
    // keep the memories re-reading the channel that is still waiting
    if (stall) begin
      step.rd_addr = count;
    end
  end

  // input stays closed up to the last step of an accepted frame
  a_ready_not_mid_frame : assert property (@(posedge clk) disable iff (reset)
    accept |-> ##num_lanes !in_ready);

endmodule

// File: corr_tap_chain.sv
module corr_tap_chain #(
  parameter int unsigned corr_sel = 0
) (
  input  logic                   clk,
  input  logic                   reset,
  input  corr_pkg::tap_step_t    step,
  input  logic                   stall,
  output corr_pkg::corr_result_t bank,
  output logic                   frame_done
);
  import corr_pkg::*;

  localparam logic [corr_len-1:0] weights = corr_table[corr_sel];

  acc_t x_pos;
  acc_t x_neg;
  acc_t tap_in  [corr_len];
  acc_t tap_out [corr_len];
  acc_t sums    [num_lanes];
  logic valid_q;
  logic wr_en;

  assign x_pos = acc_t'(step.sample);
  assign x_neg = -x_pos;

  // tap outputs are written back one cycle after their step
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (!stall) begin
      valid_q <= step.step;
    end
  end

  assign wr_en = valid_q & ~stall;
  assign frame_done = wr_en & step.last;

  //////////////////////////////
  // tap chain

  // first tap starts every channel from zero
  assign tap_in[0] = '0;

  // transposed form: tap n picks up tap n-1's sum from one frame back
  for (genvar n = 1; n < corr_len; n++) begin : g_state
    chan_state_ram i_chan_state_ram (
      .clk     (clk),
      .reset   (reset),
      .we      (wr_en),
      .wr_addr (step.wr_addr),
      .rd_addr (step.rd_addr),
      .wr_data (tap_out[n-1]),
      .rd_data (tap_in[n])
    );
  end

  // tap n sees the newest sample, so it carries weight bit corr_len-1-n
  for (genvar n = 0; n < corr_len; n++) begin : g_tap
    always_ff @(posedge clk) begin
      if (step.step) begin
        tap_out[n] <= tap_in[n] + (weights[corr_len-1-n] ? x_pos : x_neg);
      end
    end
  end

  //////////////////////////////
  // output bank

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int k = 0; k < num_lanes; k++) begin
        sums[k] <= '0;
      end
    end else if (wr_en) begin
      sums[step.wr_addr] <= tap_out[corr_len-1];
    end
  end

  // sign extension to the output lane width
  for (genvar k = 0; k < num_lanes; k++) begin : g_bank
    assign bank.lanes[k] = lane_out_t'(sums[k]);
  end

  a_done_on_last_lane : assert property (@(posedge clk) disable iff (reset)
    frame_done |-> (wr_en && step.wr_addr == lane_idx_t'(num_lanes - 1)));

endmodule

// File: run.sh
#!/usr/bin/env bash
# build the correlator testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module bit_corr_tb -f all.f -o bit_corr_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/bit_corr_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$log"; then
  echo "testbench reported failure"
  exit 1
fi

echo "simulation finished without reported failure"
exit 0

// File: tb_clock_gen.sv
module tb_clock_gen #(
  parameter int period = 20
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 1ps;

  // free-running clock, first rising edge at half a period
  initial begin
    clk = 1'b0;
    forever begin
      #(period / 2) clk = ~clk;
    end
  end

endmodule
